// ==== dv/decap_golden.txt ====
// per record: message and fault index on one line (index 11 or more means no fault),
// then u0..u3, v0..v2 (128-bit) and d0..d3 (32-bit) in return order
000102030405060708090a0b0c0d0e0f 01
8f3a21c45b7e9d06e2c41f839a6b7d25
17d4e6a2c93b5f084e7a1c6db2f8093e
6c2e9b1f03a7d4e5f81c6b297d4e0a93
d5b80e472c6f91a38e0d5b7241c9f6a8
a3e75c19f04b8d261e9c7a536b2d8f04
5f1a3c8e7d09b6e2c4a8217f93e5d60b
0e6d9f2ab81c4753e9f2063d4a7c1b85
c17e09a4
3b86f25d
9e04d7c1
62af38e9
3c9e57a1d2f0846b19e7c35a8d2b61f4 ff
2b9f6e13a74c08d5f1e63b298c05d7a4
e4170c8b5d92f6a30b7e4c19d68a2f57
71c3ad08e59b4f268a1d7e03c64b92f5
9d5e2a7104c8b3f6e27f1a9d53b60c48
f86b1d342e9a07c5b3d45f187a0e6c92
4c0f9e26d71b53a86e2c8f04b9a5137d
a05d7c931f68e2b4c97a0d51e3b48f26
5a3c91e7
e8d2047b
17f6ac35
b40e6d92
a5f0e1d2c3b4a59687786950413223fe 05
c82d4f179e6a30b527f1c84da5e90b36
3e70b9c2d4158a6f91c3e7b05f2a6d18
8b4f1e6d07a9c253e6d80f142c7b95a3
f1a6083c6d2e97b43a5c1f80d97e4b26
5c93e7a0b2148d6f0e7fa931c46b2d58
e02b6f9541d7c83a9f0e5b277a83c1d4
6a5e1c08f39d24b7c08a7e6315f2d94b
8d17b4e2
2f6e9a05
c3b81d7f
74a05ec9
7e9512270f1e2d3c4b5a69788796a5b4 09
0d9b3e57a2f48c167e1b05d9c6a83f24
b7421fe93c05d8a6e9b27f4018d6c35a
4f8ea063d1b7259c02e6f8b1a94d7e35
e365c9a07b1d4e82f5a0936c2e8b17d4
91f04b2e6c8a3d75b42e9f01d7c5a638
2a7d6e91f0c34b586d19e2a785b0f4c3
d84e1b7309a6f25c3f7bc8e0e12d4a96
6b09d3f4
f27a8c15
4e9cb06a
a15f72d8

// ==== list.f ====
src/decap_pkg.sv
src/ct_read_if.sv
src/ct_store.sv
src/msg_reorder.sv
src/ct_compare.sv
src/decap_ctrl.sv
src/decap_top.sv
dv/decap_checker.sv
dv/decap_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module decap_tb \
    -f list.f -o decap_sim > build.log 2>&1 &&
./obj_dir/decap_sim > sim.log 2>&1
grep -qx "No errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== dv/decap_tb.sv ====
`timescale 1ns/1ps

module decap_tb;
    import decap_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 2;
    localparam int NUM_RECORDS = 4;
    localparam int REC_LINES   = CT_WORDS + 2;
    localparam int REC_CYCLES  = 200;
    localparam int WATCHDOG_NS = (RST_CYCLES + NUM_RECORDS * REC_CYCLES) * CLK_PERIOD;
    localparam int unsigned SEED = 32'h1227_7e95;

    logic                clk;
    logic                rst;
    logic                start;
    logic                busy;
    logic                ct_wen;
    logic [PART_W-1:0]   ct_part;
    logic [ADDR_W-1:0]   ct_addr;
    logic [WORD_W-1:0]   ct_data;
    logic                dec_valid;
    logic                dec_ready;
    logic [MSG_W-1:0]    dec_msg;
    logic                m_valid;
    logic                m_ready;
    logic [MWORD_W-1:0]  m_word;
    logic                enc_start;
    logic                re_valid;
    logic                re_ready;
    logic [WORD_W-1:0]   re_data;
    logic                done;
    logic                match;

    // message, fault index, then 11 words in return order for each record
    logic [WORD_W-1:0]   golden [NUM_RECORDS*REC_LINES];
    int                  mismatch_count;
    int                  fail_count;

    decap_top uut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .ct_wen    (ct_wen),
        .ct_part   (ct_part),
        .ct_addr   (ct_addr),
        .ct_data   (ct_data),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_msg   (dec_msg),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_word    (m_word),
        .enc_start (enc_start),
        .re_valid  (re_valid),
        .re_ready  (re_ready),
        .re_data   (re_data),
        .done      (done),
        .match     (match)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_word(input logic [MWORD_W-1:0] got, input logic [MWORD_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_result(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        fail_count++;
    endtask

    function automatic logic [MSG_W-1:0] reverse_bytes(input logic [MSG_W-1:0] m);
        logic [MSG_W-1:0] r;
        for (int i = 0; i < MSG_BYTES; i++) begin
            r[8*i +: 8] = m[8*(MSG_BYTES-1-i) +: 8];
        end
        return r;
    endfunction

    // word k takes reversed bytes from the top down
    function automatic logic [MWORD_W-1:0] expected_word(input logic [MSG_W-1:0] m, input int k);
        logic [MSG_W-1:0] r;
        r = reverse_bytes(m);
        return r[MSG_W-1-MWORD_W*k -: MWORD_W];
    endfunction

    function automatic logic [PART_W-1:0] part_of(input int i);
        if (i < U_WORDS) begin
            return PART_U;
        end else if (i < U_WORDS + V_WORDS) begin
            return PART_V;
        end
        return PART_D;
    endfunction

    function automatic logic [ADDR_W-1:0] addr_of(input int i);
        if (i < U_WORDS) begin
            return ADDR_W'(i);
        end else if (i < U_WORDS + V_WORDS) begin
            return ADDR_W'(i - U_WORDS);
        end
        return ADDR_W'(i - U_WORDS - V_WORDS);
    endfunction

    // engine output with bit 0 flipped at the fault index
    function automatic logic [WORD_W-1:0] returned_word(input int base, input int idx,
                                                        input int fault);
        logic [WORD_W-1:0] w;
        w = golden[base + 2 + idx];
        if (idx == fault) begin
            w[0] = ~w[0];
        end
        return w;
    endfunction

    task automatic load_ciphertext(input int base);
        for (int i = 0; i < CT_WORDS; i++) begin
            @(negedge clk);
            ct_wen  = 1'b1;
            ct_part = part_of(i);
            ct_addr = addr_of(i);
            ct_data = golden[base + 2 + i];
        end
        @(negedge clk);
        ct_wen = 1'b0;
    endtask

    task automatic run_record(input int r);
        int               base;
        int               fault;
        int               cyc;
        int               msg_idx;
        int               ret_idx;
        int               last_msg_cyc;
        int               last_ret_cyc;
        int               enc_count;
        logic             exp_match;
        logic             done_seen;
        logic             re_taken;
        logic [MSG_W-1:0] msg;
        base      = r * REC_LINES;
        msg       = golden[base];
        fault     = int'(golden[base + 1][31:0]);
        exp_match = (fault >= CT_WORDS);
        load_ciphertext(base);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_result(dec_ready, 1'b1, "dec_ready one cycle after start");
        check_result(busy, 1'b1, "busy after start");
        dec_valid = 1'b1;
        dec_msg   = msg;
        // first return word offered early and held off until enc_start
        re_valid = 1'b1;
        re_data  = returned_word(base, 0, fault);
        @(negedge clk);
        dec_valid = 1'b0;
        check_result(dec_ready, 1'b0, "dec_ready low after the message transfer");
        cyc          = 0;
        msg_idx      = 0;
        ret_idx      = 0;
        enc_count    = 0;
        last_msg_cyc = -10;
        last_ret_cyc = -10;
        done_seen    = 1'b0;
        re_taken     = 1'b0;
        while (!done_seen && cyc < REC_CYCLES) begin
            if (enc_start) begin
                enc_count++;
                check_result(msg_idx == MSG_WORDS && cyc == last_msg_cyc + 2, 1'b1,
                             "enc_start two cycles after the last message word");
            end
            if (enc_count == 0) begin
                check_result(re_ready, 1'b0, "re_ready low before enc_start");
            end
            if (done) begin
                done_seen = 1'b1;
                check_result(ret_idx == CT_WORDS && cyc == last_ret_cyc + 3, 1'b1,
                             "done three cycles after the last return word");
                check_result(match, exp_match, "match at done");
            end
            m_ready = ($urandom_range(0, 3) != 0);
            if (!re_valid || re_taken) begin
                if (ret_idx < CT_WORDS && $urandom_range(0, 2) != 0) begin
                    re_valid = 1'b1;
                    re_data  = returned_word(base, ret_idx, fault);
                end else begin
                    re_valid = 1'b0;
                end
            end
            // transfers that complete on the coming edge
            if (m_valid && m_ready) begin
                if (msg_idx < MSG_WORDS) begin
                    check_word(m_word, expected_word(msg, msg_idx), "message word");
                end else begin
                    note_failure("message word offered after the last one");
                end
                msg_idx++;
                if (msg_idx == MSG_WORDS) begin
                    last_msg_cyc = cyc;
                end
            end
            re_taken = re_valid && re_ready;
            if (re_taken) begin
                if (enc_count == 0) begin
                    note_failure("return word accepted before enc_start");
                end
                ret_idx++;
                if (ret_idx == CT_WORDS) begin
                    last_ret_cyc = cyc;
                end
            end
            @(negedge clk);
            cyc++;
        end
        m_ready  = 1'b0;
        re_valid = 1'b0;
        if (!done_seen) begin
            note_failure("done never came for this record");
        end
        check_result(enc_count == 1, 1'b1, "one enc_start per run");
        check_result(busy, 1'b0, "busy low after done");
        check_result(match, exp_match, "match held after done");
    endtask

    initial begin
        void'($urandom(SEED));
        mismatch_count = 0;
        fail_count     = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        ct_wen         = 1'b0;
        ct_part        = '0;
        ct_addr        = '0;
        ct_data        = '0;
        dec_valid      = 1'b0;
        dec_msg        = '0;
        m_ready        = 1'b0;
        re_valid       = 1'b0;
        re_data        = '0;
        $readmemh("dv/decap_golden.txt", golden);
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_result(busy, 1'b0, "busy after reset");
        check_result(dec_ready, 1'b0, "dec_ready after reset");
        check_result(m_valid, 1'b0, "m_valid after reset");
        check_result(enc_start, 1'b0, "enc_start after reset");
        check_result(re_ready, 1'b0, "re_ready after reset");
        check_result(done, 1'b0, "done after reset");
        check_result(match, 1'b0, "match after reset");
        for (int r = 0; r < NUM_RECORDS; r++) begin
            run_record(r);
        end
        repeat (2) @(negedge clk);
        $display("summary: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all records finished");
        $display("summary: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== dv/decap_checker.sv ====
`timescale 1ns/1ps

module decap_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          busy,
    input logic                          m_valid,
    input logic                          m_ready,
    input logic [decap_pkg::MWORD_W-1:0] m_word,
    input logic                          enc_start,
    input logic                          re_ready,
    input logic                          done
);
    import decap_pkg::*;

    // message word held while the engine stalls
    a_word_stable: assert property (
        @(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> $stable(m_word)
    ) else $error("m_word changed while waiting for m_ready");

    // done is a single-cycle pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst)
        done |=> !done
    ) else $error("done high for two cycles in a row");

    // engine handshake only inside a run
    a_idle_quiet: assert property (
        @(posedge clk) disable iff (rst)
        !busy |-> (!enc_start && !re_ready)
    ) else $error("enc_start or re_ready high while not busy");

endmodule

bind decap_top decap_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .busy      (busy),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_word    (m_word),
    .enc_start (enc_start),
    .re_ready  (re_ready),
    .done      (done)
);

// ==== src/decap_top.sv ====
`timescale 1ns/1ps

module decap_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    output logic                          busy,
    input  logic                          ct_wen,
    input  logic [decap_pkg::PART_W-1:0]  ct_part,
    input  logic [decap_pkg::ADDR_W-1:0]  ct_addr,
    input  logic [decap_pkg::WORD_W-1:0]  ct_data,
    input  logic                          dec_valid,
    output logic                          dec_ready,
    input  logic [decap_pkg::MSG_W-1:0]   dec_msg,
    output logic                          m_valid,
    input  logic                          m_ready,
    output logic [decap_pkg::MWORD_W-1:0] m_word,
    output logic                          enc_start,
    input  logic                          re_valid,
    output logic                          re_ready,
    input  logic [decap_pkg::WORD_W-1:0]  re_data,
    output logic                          done,
    output logic                          match
);

    logic cap_go;
    logic msg_sent;
    logic cmp_go;
    logic cmp_done;

    ct_read_if rd_bus ();

    decap_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .msg_sent  (msg_sent),
        .cmp_done  (cmp_done),
        .busy      (busy),
        .cap_go    (cap_go),
        .enc_start (enc_start),
        .cmp_go    (cmp_go),
        .done      (done)
    );

    ct_store u_store (
        .clk     (clk),
        .ct_wen  (ct_wen),
        .ct_part (ct_part),
        .ct_addr (ct_addr),
        .ct_data (ct_data),
        .rd      (rd_bus.store)
    );

    msg_reorder u_reorder (
        .clk       (clk),
        .rst       (rst),
        .cap_go    (cap_go),
        .dec_valid (dec_valid),
        .dec_msg   (dec_msg),
        .m_ready   (m_ready),
        .dec_ready (dec_ready),
        .m_valid   (m_valid),
        .m_word    (m_word),
        .msg_sent  (msg_sent)
    );

    ct_compare u_compare (
        .clk      (clk),
        .rst      (rst),
        .cmp_go   (cmp_go),
        .re_valid (re_valid),
        .re_data  (re_data),
        .re_ready (re_ready),
        .cmp_done (cmp_done),
        .match    (match),
        .rd       (rd_bus.reader)
    );

endmodule

// ==== src/decap_ctrl.sv ====
`timescale 1ns/1ps

module decap_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic msg_sent,
    input  logic cmp_done,
    output logic busy,
    output logic cap_go,
    output logic enc_start,
    output logic cmp_go,
    output logic done
);
    import decap_pkg::*;

    logic [ST_W-1:0] state;
    logic            launch;

    // start only counts while idle
    assign cap_go = (state == ST_IDLE) && start;
    assign busy   = (state != ST_IDLE);
    assign done   = (state == ST_FIN);

    // engine start and compare arm share one pulse
    assign enc_start = launch;
    assign cmp_go    = launch;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            launch <= 1'b0;
        end else begin
            launch <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_MSG;
                    end
                end
                ST_MSG: begin
                    if (msg_sent) begin
                        launch <= 1'b1;
                        state  <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // re-encryption and compare run here
                    if (cmp_done) begin
                        state <= ST_FIN;
                    end
                end
                ST_FIN: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/ct_compare.sv ====
`timescale 1ns/1ps

module ct_compare (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmp_go,
    input  logic                          re_valid,
    input  logic [decap_pkg::WORD_W-1:0]  re_data,
    output logic                          re_ready,
    output logic                          cmp_done,
    output logic                          match,
    ct_read_if.reader                     rd
);
    import decap_pkg::*;

    logic              rx_active;
    logic [PART_W-1:0] part_q;
    logic [ADDR_W-1:0] addr_q;
    logic              accept;
    logic              last_word;

    // compare stage one cycle behind the read
    logic              cmp_vld;
    logic              cmp_is_d;
    logic              cmp_last;
    logic [WORD_W-1:0] word_q;
    logic              differ;

    // ready comes up together with cmp_go
    assign re_ready  = cmp_go | rx_active;
    assign accept    = re_valid & re_ready;
    assign last_word = (part_q == PART_D) && (addr_q == ADDR_W'(D_WORDS-1));

    assign rd.en   = accept;
    assign rd.part = part_q;
    assign rd.addr = addr_q;

    always_comb begin
        if (cmp_is_d) begin
            differ = word_q[D_W-1:0] != rd.data[D_W-1:0];
        end else begin
            differ = word_q != rd.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_active <= 1'b0;
            part_q    <= PART_U;
            addr_q    <= '0;
            cmp_vld   <= 1'b0;
            cmp_is_d  <= 1'b0;
            cmp_last  <= 1'b0;
            cmp_done  <= 1'b0;
            match     <= 1'b0;
        end else begin
            cmp_vld  <= accept;
            cmp_done <= cmp_vld & cmp_last;

            if (cmp_go) begin
                rx_active <= 1'b1;
                match     <= 1'b1;
            end else if (cmp_vld && differ) begin
                match <= 1'b0;
            end

            if (accept) begin
                cmp_is_d <= (part_q == PART_D);
                cmp_last <= last_word;
                // walk u, then v, then d; wrap back to u0 for the next run
                if (last_word) begin
                    rx_active <= 1'b0;
                    part_q    <= PART_U;
                    addr_q    <= '0;
                end else if (part_q == PART_U && addr_q == ADDR_W'(U_WORDS-1)) begin
                    part_q <= PART_V;
                    addr_q <= '0;
                end else if (part_q == PART_V && addr_q == ADDR_W'(V_WORDS-1)) begin
                    part_q <= PART_D;
                    addr_q <= '0;
                end else begin
                    addr_q <= addr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= re_data;
        end
    end

endmodule

// ==== src/msg_reorder.sv ====
`timescale 1ns/1ps

module msg_reorder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cap_go,
    input  logic                          dec_valid,
    input  logic [decap_pkg::MSG_W-1:0]   dec_msg,
    input  logic                          m_ready,
    output logic                          dec_ready,
    output logic                          m_valid,
    output logic [decap_pkg::MWORD_W-1:0] m_word,
    output logic                          msg_sent
);
    import decap_pkg::*;

    msg_t                 dec_view;
    msg_t                 rev;
    msg_t                 msg_q;
    logic [MSG_IDX_W-1:0] idx;

    assign dec_view = dec_msg;

    // byte i takes byte MSG_BYTES-1-i
    always_comb begin
        for (int i = 0; i < MSG_BYTES; i++) begin
            rev.b[i] = dec_view.b[MSG_BYTES-1-i];
        end
    end

    // most significant word goes first
    assign m_word = msg_q.w[MSG_IDX_W'(MSG_WORDS-1) - idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_ready <= 1'b0;
            m_valid   <= 1'b0;
            msg_sent  <= 1'b0;
            idx       <= '0;
        end else begin
            msg_sent <= 1'b0;
            if (cap_go) begin
                dec_ready <= 1'b1;
            end
            if (dec_ready && dec_valid) begin
                dec_ready <= 1'b0;
                m_valid   <= 1'b1;
                idx       <= '0;
            end
            if (m_valid && m_ready) begin
                if (idx == MSG_IDX_W'(MSG_WORDS-1)) begin
                    m_valid  <= 1'b0;
                    msg_sent <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_ready && dec_valid) begin
            msg_q <= rev;
        end
    end

endmodule

// ==== src/ct_store.sv ====
`timescale 1ns/1ps

module ct_store (
    input  logic                          clk,
    input  logic                          ct_wen,
    input  logic [decap_pkg::PART_W-1:0]  ct_part,
    input  logic [decap_pkg::ADDR_W-1:0]  ct_addr,
    input  logic [decap_pkg::WORD_W-1:0]  ct_data,
    ct_read_if.store                      rd
);
    import decap_pkg::*;

    logic [WORD_W-1:0] u_mem [U_WORDS];
    logic [WORD_W-1:0] v_mem [V_WORDS];
    logic [D_W-1:0]    d_mem [D_WORDS];

    // load port
    always_ff @(posedge clk) begin
        if (ct_wen) begin
            case (ct_part)
                PART_U: u_mem[ct_addr] <= ct_data;
                PART_V: begin
                    // v has no entry at the top address
                    if (ct_addr < ADDR_W'(V_WORDS)) begin
                        v_mem[ct_addr] <= ct_data;
                    end
                end
                PART_D: d_mem[ct_addr] <= ct_data[D_W-1:0];
                default: ;
            endcase
        end
    end

    // registered read with data valid the cycle after en
    always_ff @(posedge clk) begin
        if (rd.en) begin
            case (rd.part)
                PART_U: rd.data <= u_mem[rd.addr];
                PART_V: rd.data <= v_mem[rd.addr];
                PART_D: rd.data <= {{(WORD_W-D_W){1'b0}}, d_mem[rd.addr]};
                default: rd.data <= '0;
            endcase
        end
    end

endmodule

// ==== src/ct_read_if.sv ====
`timescale 1ns/1ps

interface ct_read_if;
    import decap_pkg::*;

    logic              en;
    logic [PART_W-1:0] part;
    logic [ADDR_W-1:0] addr;
    // d words sit in the low D_W bits
    logic [WORD_W-1:0] data;

    modport reader (
        output en, part, addr,
        input  data
    );

    modport store (
        input  en, part, addr,
        output data
    );

endinterface

// ==== src/decap_pkg.sv ====
package decap_pkg;

    // reduced simulation geometry
    localparam int WORD_W    = 128;
    localparam int D_W       = 32;
    localparam int MSG_W     = 128;
    localparam int MSG_BYTES = MSG_W / 8;
    localparam int MWORD_W   = 32;
    localparam int MSG_WORDS = MSG_W / MWORD_W;
    localparam int MSG_IDX_W = $clog2(MSG_WORDS);

    // v is one word shorter than u
    localparam int U_WORDS  = 4;
    localparam int V_WORDS  = U_WORDS - 1;
    localparam int D_WORDS  = 4;
    localparam int CT_WORDS = U_WORDS + V_WORDS + D_WORDS;

    // part select codes
    localparam int PART_W = 2;
    localparam logic [PART_W-1:0] PART_D = 2'd1;
    localparam logic [PART_W-1:0] PART_U = 2'd2;
    localparam logic [PART_W-1:0] PART_V = 2'd3;

    localparam int ADDR_W = 2;

    // sequencer states
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
    localparam logic [ST_W-1:0] ST_MSG  = 2'd1;
    localparam logic [ST_W-1:0] ST_WAIT = 2'd2;
    localparam logic [ST_W-1:0] ST_FIN  = 2'd3;

    // byte view for reversal, word view for streaming
    typedef union packed {
        logic [MSG_BYTES-1:0][7:0]       b;
        logic [MSG_WORDS-1:0][MWORD_W-1:0] w;
    } msg_t;

endpackage
